//--- hdl/jam_pkg.sv
`default_nettype none

package jam_pkg;

	// ----------------------------------------------------------
	// sizes
	// ----------------------------------------------------------
	localparam int n_jobs  = 8;
	localparam int cost_w  = 7;
	localparam int idx_w   = 3;

	// holds 0 to 8 zeros
	localparam int count_w = 4;

	// sum of all minima stays below 8 x 127
	localparam int bound_w = 10;

	// ----------------------------------------------------------
	// types
	// ----------------------------------------------------------
	typedef logic [cost_w-1:0] cost_t;

	// row index first, column index second
	typedef cost_t [n_jobs-1:0][n_jobs-1:0] cost_matrix_t;

	typedef logic [bound_w-1:0] bound_t;
	typedef logic [count_w-1:0] count_t;

	// start value of a lane minimum
	localparam cost_t cost_max = '1;

	// last row, column or beat index
	localparam logic [idx_w-1:0] last_idx = idx_w'(n_jobs - 1);

endpackage

`default_nettype wire

//--- hdl/cost_loader.sv
`timescale 1ns/10ps
`default_nettype none

module cost_loader import jam_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_valid,
	input  cost_t        in_cost,
	output logic         load_done,
	output cost_matrix_t load_matrix
);

	localparam int total_w = n_jobs * n_jobs * cost_w;

	logic [5:0]         sample_cnt;
	logic               last_sample;
	logic [total_w-1:0] shift_reg;
	logic [total_w-1:0] shift_nxt;

	// ----------------------------------------------------------
	// serial to parallel
	// ----------------------------------------------------------

	// newest value enters at the top, so after 64 shifts
	// row 0 col 0 sits in the lowest bits
	assign shift_nxt = {in_cost, shift_reg[total_w-1:cost_w]};

	assign last_sample = in_valid && (sample_cnt == 6'd63);

	always_ff @(posedge clk) begin
		if (in_valid) begin
			shift_reg <= shift_nxt;
		end
		if (last_sample) begin
			load_matrix <= cost_matrix_t'(shift_nxt);
		end
	end

	// ----------------------------------------------------------
	// sample counter
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt <= '0;
			load_done  <= 1'b0;
		end else begin
			load_done <= last_sample;
			// wraps to 0 after the 64th sample
			if (in_valid) begin
				sample_cnt <= sample_cnt + 6'd1;
			end
		end
	end

	// in_valid only falls on a block boundary
	a_block_whole: assert property (
		@(posedge clk) disable iff (!rst_n)
		$fell(in_valid) |-> (sample_cnt == 6'd0)
	) else $error("in_valid dropped after %0d samples of a matrix", sample_cnt);

endmodule

`default_nettype wire

//--- hdl/min_reducer.sv
`timescale 1ns/10ps
`default_nettype none

module min_reducer import jam_pkg::*; #(
	parameter bit reduce_cols = 1'b1
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  cost_matrix_t in_matrix,
	output logic         done,
	output cost_matrix_t out_matrix,
	output bound_t       out_bound
);

	cost_matrix_t       work;
	cost_matrix_t       reduced;
	cost_t [n_jobs-1:0] lane_min;
	cost_t [n_jobs-1:0] slice_val;
	cost_t [n_jobs-1:0] min_nxt;
	bound_t             min_sum;
	logic [idx_w-1:0]   slice;
	logic               scanning;
	logic               subtracting;

	// ----------------------------------------------------------
	// scan
	// ----------------------------------------------------------

	// lanes are columns and slices rows when reducing columns
	// and the other way round when reducing rows
	always_comb begin
		for (int lane = 0; lane < n_jobs; lane++) begin
			if (reduce_cols) begin
				slice_val[lane] = work[slice][lane];
			end else begin
				slice_val[lane] = work[lane][slice];
			end
			if (slice_val[lane] < lane_min[lane]) begin
				min_nxt[lane] = slice_val[lane];
			end else begin
				min_nxt[lane] = lane_min[lane];
			end
		end
	end

	// ----------------------------------------------------------
	// subtract and sum
	// ----------------------------------------------------------
	always_comb begin
		for (int r = 0; r < n_jobs; r++) begin
			for (int c = 0; c < n_jobs; c++) begin
				// no underflow as the minimum is one of the lane values
				if (reduce_cols) begin
					reduced[r][c] = work[r][c] - lane_min[c];
				end else begin
					reduced[r][c] = work[r][c] - lane_min[r];
				end
			end
		end
	end

	always_comb begin
		min_sum = '0;
		for (int lane = 0; lane < n_jobs; lane++) begin
			min_sum = min_sum + bound_t'(lane_min[lane]);
		end
	end

	// ----------------------------------------------------------
	// datapath registers
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (start) begin
			work     <= in_matrix;
			lane_min <= {n_jobs{cost_max}};
		end else if (scanning) begin
			lane_min <= min_nxt;
		end
		if (subtracting) begin
			out_matrix <= reduced;
			out_bound  <= min_sum;
		end
	end

	// ----------------------------------------------------------
	// sequencing
	// ----------------------------------------------------------

	// capture, 8 scan edges, then one subtract edge with done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scanning    <= 1'b0;
			subtracting <= 1'b0;
			slice       <= '0;
			done        <= 1'b0;
		end else begin
			done        <= subtracting;
			subtracting <= scanning && (slice == last_idx);
			if (start) begin
				scanning <= 1'b1;
				slice    <= '0;
			end else if (scanning) begin
				slice <= slice + 1'b1;
				if (slice == last_idx) begin
					scanning <= 1'b0;
				end
			end
		end
	end

	// upstream spacing keeps this stage free
	a_start_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |-> (!scanning && !subtracting)
	) else $error("start arrived while a scan was in progress");

	// fixed latency, relied on by the report timing
	a_done_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |-> ##10 done
	) else $error("done not seen 10 cycles after start");

endmodule

`default_nettype wire

//--- hdl/reduction_report.sv
`timescale 1ns/10ps
`default_nettype none

module reduction_report import jam_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         col_done,
	input  bound_t       col_bound,
	input  logic         row_done,
	input  cost_matrix_t row_matrix,
	input  bound_t       row_bound,
	output logic         out_valid,
	output count_t       out_job,
	output bound_t       out_cost
);

	bound_t              col_bound_hold;
	bound_t              total;
	count_t [n_jobs-1:0] row_zeros;
	count_t [n_jobs-1:0] zeros_nxt;
	logic [idx_w-1:0]    beat;
	logic                burst_active;

	// ----------------------------------------------------------
	// zero count and bound
	// ----------------------------------------------------------
	always_comb begin
		for (int r = 0; r < n_jobs; r++) begin
			zeros_nxt[r] = '0;
			for (int c = 0; c < n_jobs; c++) begin
				zeros_nxt[r] = zeros_nxt[r] + count_t'(row_matrix[r][c] == '0);
			end
		end
	end

	// column bound of the matrix now in the row reducer
	always_ff @(posedge clk) begin
		if (col_done) begin
			col_bound_hold <= col_bound;
		end
		if (row_done) begin
			row_zeros <= zeros_nxt;
			total     <= col_bound_hold + row_bound;
		end
	end

	// ----------------------------------------------------------
	// output burst
	// ----------------------------------------------------------

	// one beat per row, total repeated on every beat
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			burst_active <= 1'b0;
			beat         <= '0;
			out_valid    <= 1'b0;
			out_job      <= '0;
			out_cost     <= '0;
		end else begin
			if (row_done) begin
				burst_active <= 1'b1;
				beat         <= '0;
			end else if (burst_active) begin
				beat <= beat + 1'b1;
				if (beat == last_idx) begin
					burst_active <= 1'b0;
				end
			end

			out_valid <= burst_active;
			if (burst_active) begin
				out_job  <= row_zeros[beat];
				out_cost <= total;
			end else begin
				out_job  <= '0;
				out_cost <= '0;
			end
		end
	end

	// next matrix only finishes after the burst is out
	a_no_overlap: assert property (
		@(posedge clk) disable iff (!rst_n)
		row_done |-> !burst_active
	) else $error("row_done arrived during an output burst");

	// exactly 8 beats per burst
	a_burst_len: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> ##7 out_valid ##1 !out_valid
	) else $error("output burst was not 8 beats long");

endmodule

`default_nettype wire

//--- hdl/jam_top.sv
`timescale 1ns/10ps
`default_nettype none

module jam_top import jam_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  cost_t  in_cost,
	output logic   out_valid,
	output count_t out_job,
	output bound_t out_cost
);

	logic         load_done;
	cost_matrix_t load_matrix;
	logic         col_done;
	cost_matrix_t col_matrix;
	bound_t       col_bound;
	logic         row_done;
	cost_matrix_t row_matrix;
	bound_t       row_bound;

	cost_loader u_loader (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_cost     (in_cost),
		.load_done   (load_done),
		.load_matrix (load_matrix)
	);

	// column minima first
	min_reducer #(
		.reduce_cols (1'b1)
	) u_col_reducer (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (load_done),
		.in_matrix  (load_matrix),
		.done       (col_done),
		.out_matrix (col_matrix),
		.out_bound  (col_bound)
	);

	// then row minima of the column-reduced matrix
	min_reducer #(
		.reduce_cols (1'b0)
	) u_row_reducer (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (col_done),
		.in_matrix  (col_matrix),
		.done       (row_done),
		.out_matrix (row_matrix),
		.out_bound  (row_bound)
	);

	reduction_report u_report (
		.clk        (clk),
		.rst_n      (rst_n),
		.col_done   (col_done),
		.col_bound  (col_bound),
		.row_done   (row_done),
		.row_matrix (row_matrix),
		.row_bound  (row_bound),
		.out_valid  (out_valid),
		.out_job    (out_job),
		.out_cost   (out_cost)
	);

endmodule

`default_nettype wire

//--- bench/jam_model.svh
`ifndef JAM_MODEL_SVH
`define JAM_MODEL_SVH

typedef count_t [n_jobs-1:0] zero_counts_t;

// each column loses its smallest entry
function automatic cost_matrix_t model_col_reduce(input cost_matrix_t m, output int taken);
	cost_matrix_t res;
	int low;
	taken = 0;
	for (int c = 0; c < n_jobs; c++) begin
		low = int'(m[0][c]);
		for (int r = 1; r < n_jobs; r++) begin
			if (int'(m[r][c]) < low) begin
				low = int'(m[r][c]);
			end
		end
		for (int r = 0; r < n_jobs; r++) begin
			res[r][c] = cost_t'(int'(m[r][c]) - low);
		end
		taken = taken + low;
	end
	return res;
endfunction

// each row loses its smallest entry
function automatic cost_matrix_t model_row_reduce(input cost_matrix_t m, output int taken);
	cost_matrix_t res;
	int low;
	taken = 0;
	for (int r = 0; r < n_jobs; r++) begin
		low = int'(m[r][0]);
		for (int c = 1; c < n_jobs; c++) begin
			if (int'(m[r][c]) < low) begin
				low = int'(m[r][c]);
			end
		end
		for (int c = 0; c < n_jobs; c++) begin
			res[r][c] = cost_t'(int'(m[r][c]) - low);
		end
		taken = taken + low;
	end
	return res;
endfunction

function automatic zero_counts_t model_zero_counts(input cost_matrix_t m);
	zero_counts_t counts;
	int n;
	for (int r = 0; r < n_jobs; r++) begin
		n = 0;
		for (int c = 0; c < n_jobs; c++) begin
			if (m[r][c] == '0) begin
				n = n + 1;
			end
		end
		counts[r] = count_t'(n);
	end
	return counts;
endfunction

// column pass first, then rows of the column-reduced matrix
task automatic model_result(input cost_matrix_t m, output zero_counts_t counts,
		output bound_t bound);
	cost_matrix_t col_m;
	cost_matrix_t row_m;
	int col_sum;
	int row_sum;
	col_m = model_col_reduce(m, col_sum);
	row_m = model_row_reduce(col_m, row_sum);
	counts = model_zero_counts(row_m);
	bound = bound_t'(col_sum + row_sum);
endtask

`endif

//--- bench/jam_tb.sv
`timescale 1ns/10ps
`default_nettype none

module jam_tb import jam_pkg::*; ();

	localparam int n_matrices = 25;
	localparam int cycle_limit = (n_matrices + 2) * 64 + 100;

	logic   clk;
	logic   rst_n;
	logic   in_valid;
	cost_t  in_cost;
	logic   out_valid;
	count_t out_job;
	bound_t out_cost;

	int    seed = 32'hfe58;
	int    error_count = 0;
	int    test_start_errors = 0;
	int    pass_count = 0;
	int    fail_count = 0;
	int    cycle_count = 0;
	int    beat_idx = 0;
	string test_name = "reset";

	`include "jam_model.svh"

	zero_counts_t exp_counts[$];
	bound_t       exp_bounds[$];

	jam_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_cost   (in_cost),
		.out_valid (out_valid),
		.out_job   (out_job),
		.out_cost  (out_cost)
	);

	always #5 clk = ~clk;

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	task automatic compare(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("MISMATCH %s: %s expected %0d actual %0d", test_name, what, expected,
				actual);
			error_count++;
		end
	endtask

	function automatic cost_matrix_t random_matrix();
		cost_matrix_t m;
		for (int r = 0; r < n_jobs; r++) begin
			for (int c = 0; c < n_jobs; c++) begin
				m[r][c] = cost_t'($random(seed));
			end
		end
		return m;
	endfunction

	function automatic cost_matrix_t filled_matrix(input cost_t v);
		cost_matrix_t m;
		for (int r = 0; r < n_jobs; r++) begin
			for (int c = 0; c < n_jobs; c++) begin
				m[r][c] = v;
			end
		end
		return m;
	endfunction

	// row-major, one value per cycle
	task automatic drive_matrix(input cost_matrix_t m);
		for (int r = 0; r < n_jobs; r++) begin
			for (int c = 0; c < n_jobs; c++) begin
				@(posedge clk);
				#1;
				in_valid = 1'b1;
				in_cost  = m[r][c];
			end
		end
	endtask

	task automatic stop_input();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_cost  = '0;
	endtask

	task automatic expect_model(input cost_matrix_t m);
		zero_counts_t counts;
		bound_t bound;
		model_result(m, counts, bound);
		exp_counts.push_back(counts);
		exp_bounds.push_back(bound);
	endtask

	// same count on every row
	task automatic expect_uniform(input int zeros, input int bound);
		zero_counts_t counts;
		for (int r = 0; r < n_jobs; r++) begin
			counts[r] = count_t'(zeros);
		end
		exp_counts.push_back(counts);
		exp_bounds.push_back(bound_t'(bound));
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errors = error_count;
	endtask

	task automatic end_test();
		while (exp_bounds.size() != 0) begin
			@(posedge clk);
		end
		// one more cycle so the monitor sees out_valid fall
		@(posedge clk);
		if (error_count == test_start_errors) begin
			$display("test %s: ok", test_name);
			pass_count++;
		end else begin
			$display("test %s: failed with %0d errors", test_name,
				error_count - test_start_errors);
			fail_count++;
		end
	endtask

	// ----------------------------------------------------------
	// output monitor
	// ----------------------------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (exp_bounds.size() == 0) begin
					$display("test %s: output beat seen with no burst expected", test_name);
					error_count++;
				end else begin
					compare("zero count", int'(exp_counts[0][beat_idx]), int'(out_job));
					compare("bound", int'(exp_bounds[0]), int'(out_cost));
					if (beat_idx == n_jobs - 1) begin
						beat_idx = 0;
						void'(exp_counts.pop_front());
						void'(exp_bounds.pop_front());
					end else begin
						beat_idx++;
					end
				end
			end else begin
				if (beat_idx != 0) begin
					$display("test %s: burst ended after only %0d beats", test_name, beat_idx);
					error_count++;
					beat_idx = 0;
					void'(exp_counts.pop_front());
					void'(exp_bounds.pop_front());
				end
				compare("idle out_job", 0, int'(out_job));
				compare("idle out_cost", 0, int'(out_cost));
			end
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles, %0d bursts never arrived",
				cycle_count, exp_bounds.size());
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// tests
	// ----------------------------------------------------------
	initial begin
		cost_matrix_t m;
		cost_t v;
		clk      = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_cost  = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		begin_test("reset");
		repeat (3) begin
			@(negedge clk);
			compare("out_valid", 0, int'(out_valid));
			compare("out_job", 0, int'(out_job));
			compare("out_cost", 0, int'(out_cost));
		end
		end_test();

		begin_test("random");
		m = random_matrix();
		expect_model(m);
		drive_matrix(m);
		stop_input();
		end_test();

		begin_test("constant");
		v = cost_t'($random(seed));
		expect_uniform(n_jobs, n_jobs * int'(v));
		drive_matrix(filled_matrix(v));
		stop_input();
		end_test();

		begin_test("all_max");
		expect_uniform(n_jobs, 1016);
		drive_matrix(filled_matrix(7'd127));
		stop_input();
		end_test();

		begin_test("all_zero");
		expect_uniform(n_jobs, 0);
		drive_matrix(filled_matrix(7'd0));
		stop_input();
		end_test();

		begin_test("single_column");
		m = filled_matrix(7'd0);
		for (int r = 0; r < n_jobs; r++) begin
			m[r][5] = cost_t'($random(seed)) | 7'd1;
		end
		expect_model(m);
		drive_matrix(m);
		stop_input();
		end_test();

		// no gap between matrices
		begin_test("back_to_back");
		for (int i = 0; i < 20; i++) begin
			m = random_matrix();
			expect_model(m);
			drive_matrix(m);
		end
		stop_input();
		end_test();

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
hdl/jam_pkg.sv
hdl/cost_loader.sv
hdl/min_reducer.sv
hdl/reduction_report.sv
hdl/jam_top.sv
bench/jam_tb.sv

//--- Makefile
BUILD := build
TOP   := jam_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder"

test:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) \
		--Mdir $(BUILD) -f filelist.f
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD)
